// File: rv_isa_pkg.sv
// --------------------
// rv32i instruction field positions, register numbers
// and the major opcode enum
// --------------------
package rv_isa_pkg;

    localparam int RV_INS_W = 32;

    // field positions in a 32-bit instruction
    localparam int RV_OPC_MSB    = 6;
    localparam int RV_OPC_LSB    = 0;
    localparam int RV_RD_MSB     = 11;
    localparam int RV_RD_LSB     = 7;
    localparam int RV_FUNCT3_MSB = 14;
    localparam int RV_FUNCT3_LSB = 12;
    localparam int RV_RS1_MSB    = 19;
    localparam int RV_RS1_LSB    = 15;
    localparam int RV_IMM12_MSB  = 31;
    localparam int RV_IMM12_LSB  = 20;

    // low two bits of a full-width (non-compressed) instruction
    localparam logic [1:0] RV_QUAD_32 = 2'b11;

    // abi register numbers
    localparam logic [4:0] RV_REG_RA = 5'd1;
    localparam logic [4:0] RV_REG_SP = 5'd2;

    localparam logic [2:0] RV_FUNCT3_ADD  = 3'd0;
    localparam logic [2:0] RV_FUNCT3_PRIV = 3'd0;

    // imm12 of the trap return instructions
    localparam logic [11:0] RV_FUNCT12_URET = 12'h002;
    localparam logic [11:0] RV_FUNCT12_SRET = 12'h102;
    localparam logic [11:0] RV_FUNCT12_MRET = 12'h302;

    typedef enum logic [6:0] {
        OPC_LUI     = 7'b0110111,
        OPC_AUIPC   = 7'b0010111,
        OPC_JAL     = 7'b1101111,
        OPC_JALR    = 7'b1100111,
        OPC_BRANCH  = 7'b1100011,
        OPC_LOAD    = 7'b0000011,
        OPC_STORE   = 7'b0100011,
        OPC_OPIMM   = 7'b0010011,
        OPC_OP      = 7'b0110011,
        OPC_MISCMEM = 7'b0001111,
        OPC_SYSTEM  = 7'b1110011
    } rv_opcode_e;

endpackage

// File: trace_pkg.sv
// --------------------
// trace record kinds and default record widths
// --------------------
package trace_pkg;

    // address and cause width
    localparam int XLEN_DEFAULT = 32;

    // width of the stack and trap depth counters
    localparam int DEPTH_W_DEFAULT = 16;

    // one kind per trace record
    typedef enum logic [3:0] {
        KIND_TRAP        = 4'd0,
        KIND_CALL        = 4'd1,
        KIND_RETURN      = 4'd2,
        KIND_JUMP        = 4'd3,
        KIND_BRANCH      = 4'd4,
        KIND_LOAD        = 4'd5,
        KIND_STORE       = 4'd6,
        KIND_ALU         = 4'd7,
        KIND_UPPER       = 4'd8,
        KIND_FENCE       = 4'd9,
        KIND_SYSTEM      = 4'd10,
        // mret, sret, uret
        KIND_TRAP_RETURN = 4'd11,
        KIND_OTHER       = 4'd12
    } trace_kind_e;

endpackage

// File: trace_if.sv
// --------------------
// commit event stream and trace record stream
// --------------------
`timescale 1ns/1ps

interface commit_if
    import rv_isa_pkg::*, trace_pkg::*;
#(
    parameter int XLEN = XLEN_DEFAULT
) ();
    logic                valid;
    logic                ready;
    logic                trap;
    logic [XLEN-1:0]     addr;
    logic [RV_INS_W-1:0] ins;
    logic [XLEN-1:0]     cause;

    modport src (output valid, trap, addr, ins, cause, input ready);
    modport dst (input valid, trap, addr, ins, cause, output ready);
endinterface

interface record_if
    import trace_pkg::*;
#(
    parameter int XLEN    = XLEN_DEFAULT,
    parameter int DEPTH_W = DEPTH_W_DEFAULT
) ();
    logic                      valid;
    logic                      ready;
    trace_kind_e               kind;
    logic [XLEN-1:0]           addr;
    // instruction word or trap cause
    logic [XLEN-1:0]           info;
    logic signed [DEPTH_W-1:0] stack_depth;
    logic [DEPTH_W-1:0]        trap_depth;

    modport src (output valid, kind, addr, info, stack_depth, trap_depth, input ready);
    modport dst (input valid, kind, addr, info, stack_depth, trap_depth, output ready);
endinterface

// File: commit_capture.sv
// --------------------
// one-entry input register for commit and trap events
// --------------------
`timescale 1ns/1ps

module commit_capture
    import rv_isa_pkg::*;
    import trace_pkg::*;
#(
    parameter int XLEN = XLEN_DEFAULT
) (
    input  logic                clk_i,
    input  logic                resetb_i,
    input  logic                commit_valid_i,
    output logic                commit_ready_o,
    input  logic                commit_trap_i,
    input  logic [XLEN-1:0]     commit_addr_i,
    input  logic [RV_INS_W-1:0] commit_ins_i,
    input  logic [XLEN-1:0]     commit_cause_i,
    commit_if.src               evt
);
    logic                valid_q;
    logic                trap_q;
    logic [XLEN-1:0]     addr_q;
    logic [RV_INS_W-1:0] ins_q;
    logic [XLEN-1:0]     cause_q;
    logic                accept;

    // free slot, or the held event leaves this cycle
    assign commit_ready_o = !valid_q || evt.ready;
    assign accept         = commit_valid_i && commit_ready_o;

    always_ff @(posedge clk_i or negedge resetb_i) begin
        if (!resetb_i) begin
            valid_q <= 1'b0;
        end else if (accept) begin
            valid_q <= 1'b1;
        end else if (evt.ready) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            trap_q  <= commit_trap_i;
            addr_q  <= commit_addr_i;
            ins_q   <= commit_ins_i;
            cause_q <= commit_cause_i;
        end
    end

    assign evt.valid = valid_q;
    assign evt.trap  = trap_q;
    assign evt.addr  = addr_q;
    assign evt.ins   = ins_q;
    assign evt.cause = cause_q;

endmodule

// File: ins_classifier.sv
// --------------------
// event classification, stack and trap depth counters,
// one register stage towards the record queue
// --------------------
`timescale 1ns/1ps

module ins_classifier
    import rv_isa_pkg::*;
    import trace_pkg::*;
#(
    parameter int XLEN    = XLEN_DEFAULT,
    parameter int DEPTH_W = DEPTH_W_DEFAULT
) (
    input  logic  clk_i,
    input  logic  resetb_i,
    commit_if.dst evt,
    record_if.src rec
);
    // decoded fields
    rv_opcode_e                opcode;
    logic [4:0]                rd;
    logic [4:0]                rs1;
    logic [2:0]                funct3;
    logic [11:0]               imm12;
    logic signed [DEPTH_W-1:0] imm_ext;
    logic                      is_rv32;
    logic                      is_return;
    logic                      is_xret;
    logic                      is_sp_addi;

    // next record and counters
    trace_kind_e               kind_d;
    logic [XLEN-1:0]           info_d;
    logic signed [DEPTH_W-1:0] stack_d;
    logic [DEPTH_W-1:0]        trap_d;

    logic                      rec_valid_q;
    trace_kind_e               kind_q;
    logic [XLEN-1:0]           addr_q;
    logic [XLEN-1:0]           info_q;
    logic signed [DEPTH_W-1:0] stack_q;
    logic [DEPTH_W-1:0]        trap_q;
    logic                      accept;

    // --------------------
    // decode
    // --------------------
    assign opcode  = rv_opcode_e'(evt.ins[RV_OPC_MSB:RV_OPC_LSB]);
    assign rd      = evt.ins[RV_RD_MSB:RV_RD_LSB];
    assign rs1     = evt.ins[RV_RS1_MSB:RV_RS1_LSB];
    assign funct3  = evt.ins[RV_FUNCT3_MSB:RV_FUNCT3_LSB];
    assign imm12   = evt.ins[RV_IMM12_MSB:RV_IMM12_LSB];
    assign imm_ext = DEPTH_W'($signed(imm12));
    assign is_rv32 = evt.ins[1:0] == RV_QUAD_32;

    // jalr x?, 0(x1)
    assign is_return = rs1 == RV_REG_RA && imm12 == '0;
    assign is_xret   = funct3 == RV_FUNCT3_PRIV &&
                       (imm12 == RV_FUNCT12_URET || imm12 == RV_FUNCT12_SRET ||
                        imm12 == RV_FUNCT12_MRET);
    // addi sp, sp, imm
    assign is_sp_addi = opcode == OPC_OPIMM && funct3 == RV_FUNCT3_ADD &&
                        rd == RV_REG_SP && rs1 == RV_REG_SP;

    always_comb begin
        kind_d  = KIND_OTHER;
        info_d  = XLEN'(evt.ins);
        stack_d = stack_q;
        trap_d  = trap_q;
        if (evt.trap) begin
            kind_d = KIND_TRAP;
            info_d = evt.cause;
            trap_d = trap_q + DEPTH_W'(1);
        end else if (is_rv32) begin
            case (opcode)
                OPC_JAL:     kind_d = (rd == RV_REG_RA) ? KIND_CALL : KIND_JUMP;
                OPC_JALR:    kind_d = is_return ? KIND_RETURN : KIND_JUMP;
                OPC_BRANCH:  kind_d = KIND_BRANCH;
                OPC_LOAD:    kind_d = KIND_LOAD;
                OPC_STORE:   kind_d = KIND_STORE;
                OPC_OPIMM,
                OPC_OP:      kind_d = KIND_ALU;
                OPC_LUI,
                OPC_AUIPC:   kind_d = KIND_UPPER;
                OPC_MISCMEM: kind_d = KIND_FENCE;
                OPC_SYSTEM: begin
                    if (is_xret) begin
                        kind_d = KIND_TRAP_RETURN;
                        // no underflow past zero
                        if (trap_q != '0) begin
                            trap_d = trap_q - DEPTH_W'(1);
                        end
                    end else begin
                        kind_d = KIND_SYSTEM;
                    end
                end
                default:     kind_d = KIND_OTHER;
            endcase
            if (is_sp_addi) begin
                stack_d = stack_q + imm_ext;
            end
        end
    end

    // --------------------
    // record stage
    // --------------------
    assign evt.ready = !rec_valid_q || rec.ready;
    assign accept    = evt.valid && evt.ready;

    always_ff @(posedge clk_i or negedge resetb_i) begin
        if (!resetb_i) begin
            rec_valid_q <= 1'b0;
            stack_q     <= '0;
            trap_q      <= '0;
        end else if (accept) begin
            rec_valid_q <= 1'b1;
            stack_q     <= stack_d;
            trap_q      <= trap_d;
        end else if (rec.ready) begin
            rec_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            kind_q <= kind_d;
            addr_q <= evt.addr;
            info_q <= info_d;
        end
    end

    // counters only move on accept, so they hold the record's depths
    assign rec.valid       = rec_valid_q;
    assign rec.kind        = kind_q;
    assign rec.addr        = addr_q;
    assign rec.info        = info_q;
    assign rec.stack_depth = stack_q;
    assign rec.trap_depth  = trap_q;

endmodule

// File: trace_fifo.sv
// --------------------
// trace record queue, FIFO_DEPTH entries
// --------------------
`timescale 1ns/1ps

module trace_fifo
    import trace_pkg::*;
#(
    parameter int XLEN       = XLEN_DEFAULT,
    parameter int DEPTH_W    = DEPTH_W_DEFAULT,
    parameter int FIFO_DEPTH = 4
) (
    input  logic                      clk_i,
    input  logic                      resetb_i,
    record_if.dst                     rec,
    output logic                      rec_valid_o,
    input  logic                      rec_ready_i,
    output trace_kind_e               rec_kind_o,
    output logic [XLEN-1:0]           rec_addr_o,
    output logic [XLEN-1:0]           rec_info_o,
    output logic signed [DEPTH_W-1:0] rec_stack_depth_o,
    output logic [DEPTH_W-1:0]        rec_trap_depth_o
);
    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    trace_kind_e               kind_mem  [FIFO_DEPTH];
    logic [XLEN-1:0]           addr_mem  [FIFO_DEPTH];
    logic [XLEN-1:0]           info_mem  [FIFO_DEPTH];
    logic signed [DEPTH_W-1:0] stack_mem [FIFO_DEPTH];
    logic [DEPTH_W-1:0]        trap_mem  [FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             wr_en;
    logic             rd_en;

    assign rec.ready   = count_q != CNT_W'(FIFO_DEPTH);
    assign rec_valid_o = count_q != '0;
    assign wr_en       = rec.valid && rec.ready;
    assign rd_en       = rec_valid_o && rec_ready_i;

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk_i or negedge resetb_i) begin
        if (!resetb_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr_q <= wr_ptr_q + PTR_W'(1);
            end
            if (rd_en) begin
                rd_ptr_q <= rd_ptr_q + PTR_W'(1);
            end
            case ({wr_en, rd_en})
                2'b10:   count_q <= count_q + CNT_W'(1);
                2'b01:   count_q <= count_q - CNT_W'(1);
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            kind_mem[wr_ptr_q]  <= rec.kind;
            addr_mem[wr_ptr_q]  <= rec.addr;
            info_mem[wr_ptr_q]  <= rec.info;
            stack_mem[wr_ptr_q] <= rec.stack_depth;
            trap_mem[wr_ptr_q]  <= rec.trap_depth;
        end
    end

    // oldest entry
    assign rec_kind_o        = kind_mem[rd_ptr_q];
    assign rec_addr_o        = addr_mem[rd_ptr_q];
    assign rec_info_o        = info_mem[rd_ptr_q];
    assign rec_stack_depth_o = stack_mem[rd_ptr_q];
    assign rec_trap_depth_o  = trap_mem[rd_ptr_q];

endmodule

// File: core_trace_top.sv
// --------------------
// commit trace unit top level
// capture, classifier and record queue
// --------------------
`timescale 1ns/1ps

module core_trace_top
    import rv_isa_pkg::*;
    import trace_pkg::*;
#(
    parameter int XLEN       = XLEN_DEFAULT,
    parameter int DEPTH_W    = DEPTH_W_DEFAULT,
    parameter int FIFO_DEPTH = 4
) (
    input  logic                      clk_i,
    input  logic                      resetb_i,
    // commit side
    input  logic                      commit_valid_i,
    output logic                      commit_ready_o,
    input  logic                      commit_trap_i,
    input  logic [XLEN-1:0]           commit_addr_i,
    input  logic [RV_INS_W-1:0]       commit_ins_i,
    input  logic [XLEN-1:0]           commit_cause_i,
    // record side
    output logic                      rec_valid_o,
    input  logic                      rec_ready_i,
    output trace_kind_e               rec_kind_o,
    output logic [XLEN-1:0]           rec_addr_o,
    output logic [XLEN-1:0]           rec_info_o,
    output logic signed [DEPTH_W-1:0] rec_stack_depth_o,
    output logic [DEPTH_W-1:0]        rec_trap_depth_o
);
    commit_if #(.XLEN(XLEN)) commit_link ();
    record_if #(.XLEN(XLEN), .DEPTH_W(DEPTH_W)) record_link ();

    commit_capture #(.XLEN(XLEN)) i_capture (
        .clk_i          (clk_i),
        .resetb_i       (resetb_i),
        .commit_valid_i (commit_valid_i),
        .commit_ready_o (commit_ready_o),
        .commit_trap_i  (commit_trap_i),
        .commit_addr_i  (commit_addr_i),
        .commit_ins_i   (commit_ins_i),
        .commit_cause_i (commit_cause_i),
        .evt            (commit_link.src)
    );

    ins_classifier #(.XLEN(XLEN), .DEPTH_W(DEPTH_W)) i_classifier (
        .clk_i    (clk_i),
        .resetb_i (resetb_i),
        .evt      (commit_link.dst),
        .rec      (record_link.src)
    );

    trace_fifo #(.XLEN(XLEN), .DEPTH_W(DEPTH_W), .FIFO_DEPTH(FIFO_DEPTH)) i_fifo (
        .clk_i             (clk_i),
        .resetb_i          (resetb_i),
        .rec               (record_link.dst),
        .rec_valid_o       (rec_valid_o),
        .rec_ready_i       (rec_ready_i),
        .rec_kind_o        (rec_kind_o),
        .rec_addr_o        (rec_addr_o),
        .rec_info_o        (rec_info_o),
        .rec_stack_depth_o (rec_stack_depth_o),
        .rec_trap_depth_o  (rec_trap_depth_o)
    );

endmodule

// File: core_trace_assertions.sv
// --------------------
// record queue checks, bound into trace_fifo
// --------------------
`timescale 1ns/1ps

module core_trace_assertions
    import trace_pkg::*;
#(
    parameter int XLEN       = XLEN_DEFAULT,
    parameter int DEPTH_W    = DEPTH_W_DEFAULT,
    parameter int FIFO_DEPTH = 4,
    parameter int CNT_W      = 3
) (
    input logic               clk_i,
    input logic               resetb_i,
    input logic               valid_i,
    input logic               ready_i,
    input trace_kind_e        kind_i,
    input logic [XLEN-1:0]    addr_i,
    input logic [XLEN-1:0]    info_i,
    input logic [DEPTH_W-1:0] stack_depth_i,
    input logic [DEPTH_W-1:0] trap_depth_i,
    input logic [CNT_W-1:0]   count_i
);
    // stalled output holds
    a_hold_when_stalled : assert property (@(posedge clk_i) disable iff (!resetb_i)
        valid_i && !ready_i |=> valid_i && $stable(kind_i) && $stable(addr_i) &&
        $stable(info_i) && $stable(stack_depth_i) && $stable(trap_depth_i))
        else $error("record output changed while stalled");

    // a wrap below zero would show as all ones
    a_trap_depth_floor : assert property (@(posedge clk_i) disable iff (!resetb_i)
        valid_i && kind_i == KIND_TRAP_RETURN |-> trap_depth_i != '1)
        else $error("trap depth wrapped below zero");

    a_count_range : assert property (@(posedge clk_i) disable iff (!resetb_i)
        count_i <= CNT_W'(FIFO_DEPTH))
        else $error("queue occupancy above its depth");

endmodule

bind trace_fifo core_trace_assertions #(
    .XLEN       (XLEN),
    .DEPTH_W    (DEPTH_W),
    .FIFO_DEPTH (FIFO_DEPTH),
    .CNT_W      (CNT_W)
) i_assertions (
    .clk_i         (clk_i),
    .resetb_i      (resetb_i),
    .valid_i       (rec_valid_o),
    .ready_i       (rec_ready_i),
    .kind_i        (rec_kind_o),
    .addr_i        (rec_addr_o),
    .info_i        (rec_info_o),
    .stack_depth_i (rec_stack_depth_o),
    .trap_depth_i  (rec_trap_depth_o),
    .count_i       (count_q)
);

// File: tb_core_trace.sv
// --------------------
// testbench for the commit trace unit
// events and expected records come from core_trace_testdata.txt
// --------------------
`timescale 1ns/1ps

module tb_core_trace
    import rv_isa_pkg::*;
    import trace_pkg::*;
();
    localparam int XLEN       = XLEN_DEFAULT;
    localparam int DEPTH_W    = DEPTH_W_DEFAULT;
    localparam int FIFO_DEPTH = 4;
    localparam int TIMEOUT    = 200;
    localparam int READY_PCT  = 30;
    localparam int RAND_SEED  = 62020;

    logic                clk;
    logic                resetb;
    logic                commit_valid;
    logic                commit_ready;
    logic                commit_trap;
    logic [XLEN-1:0]     commit_addr;
    logic [RV_INS_W-1:0] commit_ins;
    logic [XLEN-1:0]     commit_cause;
    logic                rec_valid;
    logic                rec_ready;
    trace_kind_e         rec_kind;
    logic [XLEN-1:0]     rec_addr;
    logic [XLEN-1:0]     rec_info;
    logic [DEPTH_W-1:0]  rec_stack;
    logic [DEPTH_W-1:0]  rec_trap_depth;

    // one entry per data file line
    string              ev_name[$];
    logic               ev_trap[$];
    logic [XLEN-1:0]    ev_addr[$];
    logic [XLEN-1:0]    ev_word[$];
    logic [3:0]         ev_kind[$];
    logic [DEPTH_W-1:0] ev_stack[$];
    logic [DEPTH_W-1:0] ev_tdepth[$];

    // indices of accepted events, oldest first
    int exp_q[$];

    int n_events;
    int received;
    int mismatch_count;
    int timeout_count;
    int other_count;

    core_trace_top #(
        .XLEN       (XLEN),
        .DEPTH_W    (DEPTH_W),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_dut (
        .clk_i             (clk),
        .resetb_i          (resetb),
        .commit_valid_i    (commit_valid),
        .commit_ready_o    (commit_ready),
        .commit_trap_i     (commit_trap),
        .commit_addr_i     (commit_addr),
        .commit_ins_i      (commit_ins),
        .commit_cause_i    (commit_cause),
        .rec_valid_o       (rec_valid),
        .rec_ready_i       (rec_ready),
        .rec_kind_o        (rec_kind),
        .rec_addr_o        (rec_addr),
        .rec_info_o        (rec_info),
        .rec_stack_depth_o (rec_stack),
        .rec_trap_depth_o  (rec_trap_depth)
    );

    always #20 clk = ~clk;

    // --------------------
    // helpers
    // --------------------
    task automatic load_events();
        int                 fd;
        int                 n;
        string              line;
        string              name;
        logic               trap;
        logic [XLEN-1:0]    addr;
        logic [XLEN-1:0]    word;
        logic [3:0]         kind;
        logic [DEPTH_W-1:0] stack;
        logic [DEPTH_W-1:0] tdepth;
        fd = $fopen("core_trace_testdata.txt", "r");
        if (fd == 0) begin
            $display("cannot open core_trace_testdata.txt");
            other_count++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() == 0 || line.getc(0) == "#" || line.getc(0) == "\n") begin
                continue;
            end
            n = $sscanf(line, "%s %h %h %h %h %h %h",
                        name, trap, addr, word, kind, stack, tdepth);
            if (n != 7) begin
                $display("malformed line in the data file: %s", line);
                other_count++;
                continue;
            end
            ev_name.push_back(name);
            ev_trap.push_back(trap);
            ev_addr.push_back(addr);
            ev_word.push_back(word);
            ev_kind.push_back(kind);
            ev_stack.push_back(stack);
            ev_tdepth.push_back(tdepth);
        end
        $fclose(fd);
    endtask

    task automatic check_value(input string name, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("mismatch %s %s: expected %h actual %h", name, field, expected, actual);
            mismatch_count++;
        end
    endtask

    task automatic compare_record(input int idx);
        check_value(ev_name[idx], "kind", 32'(ev_kind[idx]), 32'(rec_kind));
        check_value(ev_name[idx], "addr", 32'(ev_addr[idx]), 32'(rec_addr));
        check_value(ev_name[idx], "info", 32'(ev_word[idx]), 32'(rec_info));
        check_value(ev_name[idx], "stack_depth", 32'(ev_stack[idx]), 32'(rec_stack));
        check_value(ev_name[idx], "trap_depth", 32'(ev_tdepth[idx]), 32'(rec_trap_depth));
    endtask

    // holds the event until the capture register takes it
    task automatic drive_event(input int idx, output bit ok);
        int gap;
        int waited;
        bit accepted;
        gap = $urandom_range(0, 2);
        repeat (gap) begin
            @(negedge clk);
            commit_valid = 1'b0;
        end
        @(negedge clk);
        commit_valid = 1'b1;
        commit_trap  = ev_trap[idx];
        commit_addr  = ev_addr[idx];
        // the unused field gets noise
        if (ev_trap[idx]) begin
            commit_ins   = $urandom();
            commit_cause = ev_word[idx];
        end else begin
            commit_ins   = ev_word[idx];
            commit_cause = $urandom();
        end
        accepted = 1'b0;
        waited   = 0;
        ok       = 1'b1;
        while (!accepted && ok) begin
            #1;
            if (commit_ready) begin
                accepted = 1'b1;
                exp_q.push_back(idx);
            end
            @(posedge clk);
            if (!accepted) begin
                waited++;
                if (waited > TIMEOUT) begin
                    $display("timeout: event %s was never accepted", ev_name[idx]);
                    timeout_count++;
                    ok = 1'b0;
                end else begin
                    @(negedge clk);
                end
            end
        end
    endtask

    // random back-pressure on the record side
    task automatic collect_records();
        int idle;
        int idx;
        idle = 0;
        while (received < n_events && idle <= TIMEOUT) begin
            @(negedge clk);
            rec_ready = $urandom_range(0, 99) < READY_PCT;
            #1;
            if (rec_valid && rec_ready) begin
                idle = 0;
                if (exp_q.size() == 0) begin
                    $display("record at addr %h arrived with no accepted event", rec_addr);
                    other_count++;
                end else begin
                    idx = exp_q.pop_front();
                    compare_record(idx);
                end
                received++;
            end else begin
                idle++;
            end
        end
        if (received < n_events) begin
            $display("timeout: only %0d of %0d records arrived", received, n_events);
            timeout_count++;
        end
    endtask

    // --------------------
    // main sequence
    // --------------------
    initial begin
        bit ok;
        clk            = 1'b0;
        resetb         = 1'b0;
        commit_valid   = 1'b0;
        commit_trap    = 1'b0;
        commit_addr    = '0;
        commit_ins     = '0;
        commit_cause   = '0;
        rec_ready      = 1'b0;
        received       = 0;
        mismatch_count = 0;
        timeout_count  = 0;
        other_count    = 0;
        ok             = 1'b1;
        void'($urandom(RAND_SEED));

        load_events();
        n_events = ev_name.size();
        if (n_events == 0) begin
            $display("no events were read from the data file");
            other_count++;
        end

        repeat (2) @(posedge clk);
        @(negedge clk);
        resetb = 1'b1;
        #1;
        assert (commit_ready === 1'b1 && rec_valid === 1'b0) else begin
            $display("wrong handshake state after reset");
            other_count++;
        end

        fork
            begin
                for (int i = 0; i < n_events && ok; i++) begin
                    drive_event(i, ok);
                end
                @(negedge clk);
                commit_valid = 1'b0;
            end
            collect_records();
        join

        // the last record leaves the queue on the next rising edge
        @(negedge clk);
        #1;
        assert (exp_q.size() == 0 && rec_valid === 1'b0) else begin
            $display("records left over at the end of the run");
            other_count++;
        end

        $display("errors: %0d mismatch, %0d timeout, %0d other",
                 mismatch_count, timeout_count, other_count);
        if (mismatch_count + timeout_count + other_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: core_trace_testdata.txt
# name trap addr ins_or_cause kind stack_depth trap_depth, all but name in hex
# kind: 0 trap 1 call 2 return 3 jump 4 branch 5 load 6 store 7 alu 8 upper 9 fence a system b trap_return c other
lui        0 80000000 123452b7 8 0000 0000
auipc      0 80000004 00001317 8 0000 0000
beq        0 80000008 00000063 4 0000 0000
lw         0 8000000c 00012383 5 0000 0000
sw         0 80000010 00712223 6 0000 0000
add        0 80000014 007302b3 7 0000 0000
addi_x5    0 80000018 00128293 7 0000 0000
fence      0 8000001c 0000000f 9 0000 0000
ecall      0 80000020 00000073 a 0000 0000
wfi        0 80000024 10500073 a 0000 0000
c_li       0 80000028 00004501 c 0000 0000
jal_ra     0 8000002c 000000ef 1 0000 0000
jal_x0     0 80000030 0000006f 3 0000 0000
jalr_ret   0 80000034 00008067 2 0000 0000
jalr_off4  0 80000038 00408067 3 0000 0000
jalr_x5    0 8000003c 000280e7 3 0000 0000
sp_sub16   0 80000040 ff010113 7 fff0 0000
sp_sub32   0 80000044 fe010113 7 ffd0 0000
addi_x5sp  0 80000048 04010293 7 ffd0 0000
sp_add32   0 8000004c 02010113 7 fff0 0000
trap_ecall 1 80000050 0000000b 0 fff0 0001
trap_irq   1 00000100 80000007 0 fff0 0002
mret       0 00000200 30200073 b fff0 0001
sret       0 00000204 10200073 b fff0 0000
uret_zero  0 00000208 00200073 b fff0 0000
sp_add16   0 8000020c 01010113 7 0000 0000

// File: list.f
rv_isa_pkg.sv
trace_pkg.sv
trace_if.sv
commit_capture.sv
ins_classifier.sv
trace_fifo.sv
core_trace_top.sv
core_trace_assertions.sv
tb_core_trace.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_core_trace
FILELIST  = list.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q '^=== PASS ===$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
